// File: src/can_rx_macros.svh
`ifndef CAN_RX_MACROS_SVH
`define CAN_RX_MACROS_SVH

// ==================================================================
// Frame field lengths in bits
// ==================================================================

`define CAN_ID_A_LEN          11      // Base identifier
`define CAN_ID_B_LEN          18      // Identifier extension
`define CAN_DLC_LEN           4
`define CAN_DATA_MAX          64      // Eight bytes
`define CAN_CRC_LEN           15
`define CAN_EOF_LEN           7
`define CAN_INTERMISSION_LEN  2       // Third bit may already be the next SOF

// ==================================================================
// Bit stream rules
// ==================================================================

`define CAN_STUFF_RUN         5       // Equal bits before a complement is inserted
`define CAN_BUS_IDLE_LEN      11      // Recessive bits that mark a free bus

// x^15 + x^14 + x^10 + x^8 + x^7 + x^4 + x^3 + 1
`define CAN_CRC_POLY          15'h4599

`endif

// File: src/can_rx_pkg.sv
package can_rx_pkg;

	// Decoder states in frame order
	typedef enum logic [4:0] {
		st_idle,
		st_id_a,
		st_srr_rtr,         // SRR in extended, RTR in base frame
		st_ide,
		st_id_b,
		st_rtr,             // Extended frame only
		st_reserved1,       // Extended frame only
		st_reserved0,
		st_dlc,
		st_data,
		st_crc,
		st_crc_delim,
		st_ack_slot,
		st_ack_delim,
		st_eof,
		st_intermission,
		st_error_wait       // Waiting for a free bus
	} can_state_e;

	// Target register for the current frame bit
	typedef enum logic [3:0] {
		fld_none,
		fld_id_a,
		fld_srr_rtr,
		fld_ide,
		fld_id_b,
		fld_rtr,
		fld_reserved,       // Checked nowhere, not stored
		fld_dlc,
		fld_data,
		fld_crc
	} can_field_e;

	typedef enum logic [2:0] {
		err_none,
		err_stuff,
		err_form,
		err_crc,
		err_ack
	} can_error_e;

endpackage

// File: src/can_bit_if.sv
// Sampled bus bit plus destuffer status, shared by the decoder blocks
interface can_bit_if;

	logic sample;           // One clock strobe from bit timing
	logic rx_bit;           // Bus level, 0 is dominant
	logic stuff_active;     // Frame is inside the stuffed region
	logic stuff_bit;        // Current sample is an inserted bit
	logic stuff_error;      // Sixth equal bit seen

	modport destuff (
		input  sample,
		input  rx_bit,
		input  stuff_active,
		output stuff_bit,
		output stuff_error
	);

	modport control (
		input  sample,
		input  rx_bit,
		input  stuff_bit,
		input  stuff_error,
		output stuff_active
	);

	modport capture (
		input  sample,
		input  rx_bit
	);

endinterface

// File: src/can_destuff.sv
`include "can_rx_macros.svh"

module can_destuff (
	input  logic        clock,
	input  logic        reset,
	can_bit_if.destuff  bits
);

	logic       last_bit;       // Level of the current run
	logic [2:0] run_len;        // Saturates at the stuff run length
	logic       run_full;

	assign run_full = (run_len == 3'(`CAN_STUFF_RUN));

	// Both flags are combinational in the sample clock
	assign bits.stuff_bit   = bits.sample & bits.stuff_active & run_full &
		(bits.rx_bit != last_bit);
	assign bits.stuff_error = bits.sample & bits.stuff_active & run_full &
		(bits.rx_bit == last_bit);

	// Run tracking continues outside the stuffed region
	// so the recessive idle run ends at SOF and SOF opens the first run
	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			last_bit <= 1'b1;           // Bus idles recessive
			run_len  <= 3'd0;
		end
		else if (bits.sample)
		begin
			if (bits.rx_bit != last_bit)
			begin
				last_bit <= bits.rx_bit;    // Stuff bit or level change starts a new run
				run_len  <= 3'd1;
			end
			else if (!run_full)
				run_len <= run_len + 3'd1;
		end
	end

	// Stuff errors only inside a frame body
	assert property (@(posedge clock) disable iff (reset)
		$rose(bits.stuff_error) |-> bits.stuff_active);

endmodule

// File: src/can_crc15.sv
`include "can_rx_macros.svh"

module can_crc15 (
	input  logic                    clock,
	input  logic                    reset,
	input  logic                    crc_en,
	input  logic                    crc_clear,
	input  logic                    data_bit,
	output logic [`CAN_CRC_LEN-1:0] crc_value
);

	logic [`CAN_CRC_LEN-1:0] crc_base;
	logic [`CAN_CRC_LEN-1:0] crc_shift;
	logic                    crc_nxt;

	// A clear in the same clock as an enable starts from zero,
	// which lets the SOF bit enter a fresh register
	assign crc_base = crc_clear ? '0 : crc_value;

	assign crc_nxt   = data_bit ^ crc_base[`CAN_CRC_LEN-1];
	assign crc_shift = {crc_base[`CAN_CRC_LEN-2:0], 1'b0} ^
		(crc_nxt ? `CAN_CRC_POLY : '0);

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
			crc_value <= '0;
		else if (crc_en)
			crc_value <= crc_shift;     // One bit per enabled sample
		else if (crc_clear)
			crc_value <= '0;
	end

endmodule

// File: src/can_field_capture.sv
`include "can_rx_macros.svh"

module can_field_capture (
	input  logic                                  clock,
	input  logic                                  reset,
	can_bit_if.capture                            bits,
	input  can_rx_pkg::can_field_e                field_sel,
	input  logic                                  shift_en,
	input  logic                                  clear,
	output logic [`CAN_ID_A_LEN+`CAN_ID_B_LEN-1:0] id,
	output logic                                  ide,
	output logic                                  rtr,
	output logic [`CAN_DLC_LEN-1:0]               dlc,
	output logic [`CAN_DATA_MAX-1:0]              data,
	output logic [`CAN_CRC_LEN-1:0]               crc_field
);

	import can_rx_pkg::*;

	logic [`CAN_ID_A_LEN-1:0] id_a;
	logic [`CAN_ID_B_LEN-1:0] id_b;
	logic                     srr_rtr;        // Base RTR or extended SRR
	logic                     rtr_ext;        // Extended frame RTR
	logic [`CAN_DLC_LEN-1:0]  dlc_shift;

	// DLC starts from zero at SOF, so only the last bit can set the MSB
	assign dlc_shift = {dlc[`CAN_DLC_LEN-2:0], bits.rx_bit};

	// ==================================================================
	// Field shift registers
	// ==================================================================

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			id_a      <= '0;
			id_b      <= '0;
			srr_rtr   <= 1'b0;
			rtr_ext   <= 1'b0;
			ide       <= 1'b0;
			dlc       <= '0;
			data      <= '0;
			crc_field <= '0;
		end
		else if (clear)
		begin
			// New frame
			id_a <= '0;
			id_b <= '0;
			ide  <= 1'b0;               // Keeps rtr on the srr_rtr slot until IDE
			dlc  <= '0;
			data <= '0;
		end
		else if (shift_en)
		begin
			case (field_sel)
				fld_id_a:    id_a    <= {id_a[`CAN_ID_A_LEN-2:0], bits.rx_bit};
				fld_srr_rtr: srr_rtr <= bits.rx_bit;
				fld_ide:     ide     <= bits.rx_bit;
				fld_id_b:    id_b    <= {id_b[`CAN_ID_B_LEN-2:0], bits.rx_bit};
				fld_rtr:     rtr_ext <= bits.rx_bit;
				fld_dlc:     dlc     <= dlc_shift[`CAN_DLC_LEN-1] ?
					4'(`CAN_DATA_MAX / 8) : dlc_shift;      // 9..15 read as 8
				fld_data:    data    <= {data[`CAN_DATA_MAX-2:0], bits.rx_bit};
				fld_crc:     crc_field <= {crc_field[`CAN_CRC_LEN-2:0], bits.rx_bit};
				default:     ;                  // Reserved bits are not kept
			endcase
		end
	end

	// ==================================================================
	// Frame view
	// ==================================================================

	// Base id right-aligned, extended id with base part on top
	assign id  = ide ? {id_a, id_b} : {{`CAN_ID_B_LEN{1'b0}}, id_a};
	assign rtr = ide ? rtr_ext : srr_rtr;

	assert property (@(posedge clock) disable iff (reset)
		dlc <= 4'(`CAN_DATA_MAX / 8));

endmodule

// File: src/can_rx_control.sv
`include "can_rx_macros.svh"

module can_rx_control (
	input  logic                    clock,
	input  logic                    reset,
	can_bit_if.control              bits,
	input  logic [`CAN_CRC_LEN-1:0] crc_value,
	input  logic [`CAN_DLC_LEN-1:0] dlc,
	input  logic                    ide,
	input  logic                    rtr,
	input  logic [`CAN_CRC_LEN-1:0] crc_field,
	output can_rx_pkg::can_field_e  field_sel,
	output logic                    shift_en,
	output logic                    clear,
	output logic                    crc_en,
	output logic                    crc_clear,
	output logic                    frame_valid,
	output logic                    frame_error,
	output can_rx_pkg::can_error_e  error_kind
);

	import can_rx_pkg::*;

	can_state_e              state;
	can_state_e              state_next;
	logic [5:0]              bit_cnt;       // Bits taken in the current state
	logic                    bit_ok;        // Sampled frame bit, not a stuff bit
	logic                    sof;
	logic [`CAN_DLC_LEN-1:0] dlc_next;      // DLC including the bit on the bus
	logic [6:0]              data_len;
	logic                    err_hit;
	can_error_e              err_next;
	logic                    valid_hit;

	assign bit_ok   = bits.sample & ~bits.stuff_bit;
	assign dlc_next = {dlc[`CAN_DLC_LEN-2:0], bits.rx_bit};
	assign data_len = {dlc, 3'b000};

	// Dominant bit in idle or in the third intermission slot
	assign sof = bits.sample & ~bits.rx_bit & ((state == st_idle) |
		((state == st_intermission) & (bit_cnt == 6'(`CAN_INTERMISSION_LEN))));

	// A stuff bit may still follow the last CRC bit
	assign bits.stuff_active = state inside {[st_id_a:st_crc_delim]};

	// ==================================================================
	// Next state and frame checks
	// ==================================================================

	always_comb
	begin
		state_next = state;
		err_hit    = 1'b0;
		err_next   = err_none;
		valid_hit  = 1'b0;
		if (bits.stuff_error)
		begin
			err_hit  = 1'b1;
			err_next = err_stuff;
		end
		else if (bit_ok)
		begin
			case (state)
				st_idle:
					if (!bits.rx_bit)
						state_next = st_id_a;
				st_id_a:
					if (bit_cnt == 6'(`CAN_ID_A_LEN - 1))
						state_next = st_srr_rtr;
				st_srr_rtr: state_next = st_ide;
				st_ide:
					if (!bits.rx_bit)
						state_next = st_reserved0;      // Base frame
					else if (!rtr)
					begin
						err_hit  = 1'b1;                // Dominant SRR
						err_next = err_form;
					end
					else
						state_next = st_id_b;
				st_id_b:
					if (bit_cnt == 6'(`CAN_ID_B_LEN - 1))
						state_next = st_rtr;
				st_rtr:       state_next = st_reserved1;
				st_reserved1: state_next = st_reserved0;
				st_reserved0: state_next = st_dlc;
				st_dlc:
					if (bit_cnt == 6'(`CAN_DLC_LEN - 1))
						state_next = ((dlc_next == '0) || rtr) ? st_crc : st_data;
				st_data:
					if (({1'b0, bit_cnt} + 7'd1) == data_len)
						state_next = st_crc;
				st_crc:
					if (bit_cnt == 6'(`CAN_CRC_LEN - 1))
						state_next = st_crc_delim;
				st_crc_delim:
					if (bits.rx_bit)
						state_next = st_ack_slot;
					else
					begin
						err_hit  = 1'b1;
						err_next = err_form;
					end
				st_ack_slot:
					if (!bits.rx_bit)
						state_next = st_ack_delim;
					else
					begin
						err_hit  = 1'b1;                // Nobody acknowledged
						err_next = err_ack;
					end
				st_ack_delim:
					if (!bits.rx_bit)
					begin
						err_hit  = 1'b1;
						err_next = err_form;
					end
					else if (crc_value != crc_field)
					begin
						err_hit  = 1'b1;
						err_next = err_crc;
					end
					else
					begin
						valid_hit  = 1'b1;
						state_next = st_eof;
					end
				st_eof:
					if (!bits.rx_bit)
					begin
						err_hit  = 1'b1;
						err_next = err_form;
					end
					else if (bit_cnt == 6'(`CAN_EOF_LEN - 1))
						state_next = st_intermission;
				st_intermission:
					if (bit_cnt < 6'(`CAN_INTERMISSION_LEN))
					begin
						if (!bits.rx_bit)
						begin
							err_hit  = 1'b1;
							err_next = err_form;
						end
					end
					else
						state_next = bits.rx_bit ? st_idle : st_id_a;
				st_error_wait:
					if (bits.rx_bit && (bit_cnt == 6'(`CAN_BUS_IDLE_LEN - 1)))
						state_next = st_idle;
				default: state_next = st_idle;
			endcase
		end
		if (err_hit)
			state_next = st_error_wait;
	end

	// ==================================================================
	// State, counter and result registers
	// ==================================================================

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			state       <= st_idle;
			bit_cnt     <= '0;
			frame_valid <= 1'b0;
			frame_error <= 1'b0;
			error_kind  <= err_none;
		end
		else
		begin
			state       <= state_next;
			frame_valid <= valid_hit;       // One clock pulses
			frame_error <= err_hit;
			if (err_hit)
				error_kind <= err_next;
			else if (sof)
				error_kind <= err_none;     // Held until the next frame
			if (err_hit || (state_next != state) || (state == st_idle))
				bit_cnt <= '0;
			else if (bit_ok && (state == st_error_wait) && !bits.rx_bit)
				bit_cnt <= '0;              // Recessive run broken
			else if (bit_ok)
				bit_cnt <= bit_cnt + 6'd1;
		end
	end

	// ==================================================================
	// Capture and CRC steering
	// ==================================================================

	always_comb
	begin
		case (state)
			st_id_a:      field_sel = fld_id_a;
			st_srr_rtr:   field_sel = fld_srr_rtr;
			st_ide:       field_sel = fld_ide;
			st_id_b:      field_sel = fld_id_b;
			st_rtr:       field_sel = fld_rtr;
			st_reserved1: field_sel = fld_reserved;
			st_reserved0: field_sel = fld_reserved;
			st_dlc:       field_sel = fld_dlc;
			st_data:      field_sel = fld_data;
			st_crc:       field_sel = fld_crc;
			default:      field_sel = fld_none;
		endcase
	end

	assign shift_en  = bit_ok & ~bits.stuff_error &
		~(field_sel inside {fld_none, fld_reserved});
	assign clear     = sof;
	assign crc_en    = bit_ok & (sof | (state inside {[st_id_a:st_data]}));
	assign crc_clear = (state == st_idle) | sof;

	assert property (@(posedge clock) disable iff (reset)
		!(frame_valid && frame_error));

	// Capture has latched the recessive IDE bit by the time id_b starts
	assert property (@(posedge clock) disable iff (reset)
		(state == st_id_b) |-> ide);

endmodule

// File: src/can_rx_top.sv
`include "can_rx_macros.svh"

module can_rx_top (
	input  logic                                  clock,
	input  logic                                  reset,
	input  logic                                  rx_bit,
	input  logic                                  sample_point,
	output logic                                  frame_valid,
	output logic                                  frame_error,
	output can_rx_pkg::can_error_e                error_kind,
	output logic [`CAN_ID_A_LEN+`CAN_ID_B_LEN-1:0] id,
	output logic                                  ide,
	output logic                                  rtr,
	output logic [`CAN_DLC_LEN-1:0]               dlc,
	output logic [`CAN_DATA_MAX-1:0]              data
);

	import can_rx_pkg::*;

	can_bit_if bits ();

	can_field_e              field_sel;
	logic                    shift_en;
	logic                    clear;         // SOF seen
	logic                    crc_en;
	logic                    crc_clear;
	logic [`CAN_CRC_LEN-1:0] crc_value;     // Calculated
	logic [`CAN_CRC_LEN-1:0] crc_field;     // Received

	assign bits.sample = sample_point;
	assign bits.rx_bit = rx_bit;

	// ==================================================================
	// Bit level
	// ==================================================================

	can_destuff u_destuff (
		.clock (clock),
		.reset (reset),
		.bits  (bits.destuff)
	);

	can_crc15 u_crc15 (
		.clock     (clock),
		.reset     (reset),
		.crc_en    (crc_en),
		.crc_clear (crc_clear),
		.data_bit  (rx_bit),
		.crc_value (crc_value)
	);

	// ==================================================================
	// Frame level
	// ==================================================================

	can_field_capture u_capture (
		.clock     (clock),
		.reset     (reset),
		.bits      (bits.capture),
		.field_sel (field_sel),
		.shift_en  (shift_en),
		.clear     (clear),
		.id        (id),
		.ide       (ide),
		.rtr       (rtr),
		.dlc       (dlc),
		.data      (data),
		.crc_field (crc_field)
	);

	can_rx_control u_control (
		.clock       (clock),
		.reset       (reset),
		.bits        (bits.control),
		.crc_value   (crc_value),
		.dlc         (dlc),
		.ide         (ide),
		.rtr         (rtr),
		.crc_field   (crc_field),
		.field_sel   (field_sel),
		.shift_en    (shift_en),
		.clear       (clear),
		.crc_en      (crc_en),
		.crc_clear   (crc_clear),
		.frame_valid (frame_valid),
		.frame_error (frame_error),
		.error_kind  (error_kind)
	);

endmodule

// File: tests/tb_can_rx.sv
`include "can_rx_macros.svh"

module tb_can_rx;

	import can_rx_pkg::*;

	localparam int vec_words   = 8;         // Columns per frame line
	localparam int max_frames  = 32;
	localparam int fault_crc   = 1;
	localparam int fault_stuff = 2;
	localparam int fault_ack   = 3;
	localparam int fault_delim = 4;

	logic        clock;
	logic        reset;
	logic        rx_bit;
	logic        sample_point;
	logic        frame_valid;
	logic        frame_error;
	can_error_e  error_kind;
	logic [28:0] id;
	logic        ide;
	logic        rtr;
	logic [3:0]  dlc;
	logic [63:0] data;

	logic [63:0] vec_mem [0:vec_words*max_frames-1];
	bit          raw_q[$];              // Frame bits before stuffing
	bit          stream_q[$];           // Bits as they go on the bus
	logic [31:0] lfsr;
	int          first_stuff;
	int          frame_count;
	int          valid_seen;
	int          error_seen;
	int          cycle_count;
	int          cycle_limit;

	can_rx_top DUT (
		.clock        (clock),
		.reset        (reset),
		.rx_bit       (rx_bit),
		.sample_point (sample_point),
		.frame_valid  (frame_valid),
		.frame_error  (frame_error),
		.error_kind   (error_kind),
		.id           (id),
		.ide          (ide),
		.rtr          (rtr),
		.dlc          (dlc),
		.data         (data)
	);

	always #20 clock = ~clock;

	// ======================================================================
	// Helpers
	// ======================================================================

	function automatic logic [31:0] lfsr_next(input logic [31:0] state);
		lfsr_next = state[0] ? ((state >> 1) ^ 32'h80200003) : (state >> 1);
	endfunction

	// CRC over everything now in raw_q, SOF to last data bit
	function automatic logic [14:0] body_crc();
		logic [14:0] c;
		logic        nxt;
		c = '0;
		for (int i = 0; i < raw_q.size(); i++)
		begin
			nxt = raw_q[i] ^ c[14];
			c   = {c[13:0], 1'b0};
			if (nxt)
				c = c ^ `CAN_CRC_POLY;
		end
		return c;
	endfunction

	task check(input string name, input logic [63:0] actual, input logic [63:0] expected);
		if (actual !== expected)
		begin
			$display("Mismatch at time %0t: %s is %h, expected %h", $time, name, actual,
				expected);
			$display("Simulation finished: FAIL");
			$fatal(1);
		end
	endtask

	// One strobe clock, then 1 to 4 idle clocks
	task send_bit(input bit b);
		int gap;
		@(negedge clock);
		rx_bit       = b;
		sample_point = 1'b1;
		lfsr = lfsr_next(lfsr);
		gap  = lfsr[0];
		lfsr = lfsr_next(lfsr);
		gap  = gap * 2 + lfsr[0] + 1;
		@(negedge clock);
		sample_point = 1'b0;
		repeat (gap) @(negedge clock);
	endtask

	// Frame line f into stream_q, fault applied, trailer and idle appended
	task build_frame(input int f);
		logic        v_ide;
		logic        v_rtr;
		logic [28:0] v_id;
		logic [3:0]  v_dlc;
		logic [63:0] v_data;
		int          v_fault;
		int          n_data;
		logic [14:0] crc;
		bit          run_bit;
		int          run_len;
		v_ide   = vec_mem[f*vec_words][0];
		v_rtr   = vec_mem[f*vec_words+1][0];
		v_id    = vec_mem[f*vec_words+2][28:0];
		v_dlc   = vec_mem[f*vec_words+3][3:0];
		v_data  = vec_mem[f*vec_words+4];
		v_fault = int'(vec_mem[f*vec_words+5][3:0]);
		n_data  = v_rtr ? 0 : ((v_dlc > 8) ? 64 : v_dlc * 8);
		raw_q.delete();
		stream_q.delete();
		raw_q.push_back(1'b0);                              // SOF
		if (v_ide)
		begin
			for (int i = 28; i >= 18; i--)
				raw_q.push_back(v_id[i]);
			raw_q.push_back(1'b1);                          // SRR
			raw_q.push_back(1'b1);                          // IDE
			for (int i = 17; i >= 0; i--)
				raw_q.push_back(v_id[i]);
			raw_q.push_back(v_rtr);
			raw_q.push_back(1'b0);                          // r1
		end
		else
		begin
			for (int i = 10; i >= 0; i--)
				raw_q.push_back(v_id[i]);
			raw_q.push_back(v_rtr);
			raw_q.push_back(1'b0);                          // IDE
		end
		raw_q.push_back(1'b0);                              // r0
		for (int i = 3; i >= 0; i--)
			raw_q.push_back(v_dlc[i]);
		for (int i = n_data - 1; i >= 0; i--)
			raw_q.push_back(v_data[i]);
		crc = body_crc();
		if (v_fault == fault_crc)
			crc[0] = ~crc[0];
		for (int i = 14; i >= 0; i--)
			raw_q.push_back(crc[i]);

		// Stuffing from SOF through CRC, stuff bits open the next run
		run_bit     = 1'b1;
		run_len     = 0;
		first_stuff = -1;
		foreach (raw_q[i])
		begin
			stream_q.push_back(raw_q[i]);
			if (raw_q[i] == run_bit)
				run_len++;
			else
			begin
				run_bit = raw_q[i];
				run_len = 1;
			end
			if (run_len == `CAN_STUFF_RUN)
			begin
				stream_q.push_back(~run_bit);
				if (first_stuff < 0)
					first_stuff = stream_q.size() - 1;
				run_bit = ~run_bit;
				run_len = 1;
			end
		end
		if (v_fault == fault_stuff)
			stream_q[first_stuff] = ~stream_q[first_stuff];   // Sixth equal bit

		stream_q.push_back(v_fault != fault_delim);         // CRC delimiter
		stream_q.push_back(v_fault == fault_ack);           // ACK slot, dominant when acked
		stream_q.push_back(1'b1);                           // ACK delimiter
		repeat (`CAN_EOF_LEN + `CAN_BUS_IDLE_LEN)
			stream_q.push_back(1'b1);
	endtask

	task check_result(input int f, input int valid_cnt, input int error_cnt);
		logic        v_ide;
		logic        v_rtr;
		logic [28:0] v_id;
		logic [63:0] v_data;
		logic [3:0]  exp_dlc;
		logic [2:0]  exp_kind;
		logic [63:0] exp_data;
		int          n_data;
		v_ide    = vec_mem[f*vec_words][0];
		v_rtr    = vec_mem[f*vec_words+1][0];
		v_id     = vec_mem[f*vec_words+2][28:0];
		v_data   = vec_mem[f*vec_words+4];
		exp_dlc  = vec_mem[f*vec_words+6][3:0];
		exp_kind = vec_mem[f*vec_words+7][2:0];
		check("error_kind", 64'(error_kind), 64'(exp_kind));
		if (exp_kind == 3'(err_none))
		begin
			check("frame_valid pulses", 64'(valid_cnt), 64'd1);
			check("frame_error pulses", 64'(error_cnt), 64'd0);
			n_data   = v_rtr ? 0 : exp_dlc * 8;
			exp_data = (n_data == 64) ? v_data : (v_data & ((64'd1 << n_data) - 64'd1));
			check("id", 64'(id), v_ide ? 64'(v_id) : 64'(v_id[10:0]));   // Base id right-aligned
			check("ide", 64'(ide), 64'(v_ide));
			check("rtr", 64'(rtr), 64'(v_rtr));
			check("dlc", 64'(dlc), 64'(exp_dlc));
			check("data", data, exp_data);
		end
		else
		begin
			check("frame_valid pulses", 64'(valid_cnt), 64'd0);
			check("frame_error pulses", 64'(error_cnt), 64'd1);
		end
	endtask

	// ======================================================================
	// Result monitor and run limit
	// ======================================================================

	always @(negedge clock)
	begin
		if (frame_valid)
			valid_seen++;
		if (frame_error)
			error_seen++;
	end

	always @(posedge clock)
	begin
		cycle_count++;
		if ((cycle_limit > 0) && (cycle_count >= cycle_limit))
		begin
			$display("Timeout: decoder gave no result within %0d cycles", cycle_limit);
			$display("Simulation finished: FAIL");
			$fatal(1);
		end
	end

	// ======================================================================
	// Stimulus
	// ======================================================================

	initial
	begin
		int total_bits;
		int valid_before;
		int error_before;
		clock        = 1'b0;
		reset        = 1'b1;
		rx_bit       = 1'b1;            // Recessive bus
		sample_point = 1'b0;
		lfsr         = 32'h5f5ef769;
		valid_seen   = 0;
		error_seen   = 0;
		cycle_count  = 0;
		cycle_limit  = 0;
		$readmemh("tests/can_frame_vectors.txt", vec_mem);
		frame_count = 0;
		while ((frame_count < max_frames) && !$isunknown(vec_mem[frame_count*vec_words]))
			frame_count++;
		if (frame_count == 0)
		begin
			$display("No test frames could be read from tests/can_frame_vectors.txt");
			$display("Simulation finished: FAIL");
			$fatal(1);
		end

		// Up to 5 clocks per bit
		total_bits = `CAN_BUS_IDLE_LEN;
		for (int f = 0; f < frame_count; f++)
		begin
			build_frame(f);
			total_bits += stream_q.size();
		end
		cycle_limit = total_bits * 5 + 200;

		repeat (2) @(negedge clock);
		reset = 1'b0;
		repeat (`CAN_BUS_IDLE_LEN) send_bit(1'b1);

		for (int f = 0; f < frame_count; f++)
		begin
			build_frame(f);
			valid_before = valid_seen;
			error_before = error_seen;
			foreach (stream_q[i])
				send_bit(stream_q[i]);
			@(posedge clock);
			while ((valid_seen + error_seen) == (valid_before + error_before))
				@(posedge clock);
			check_result(f, valid_seen - valid_before, error_seen - error_before);
		end

		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

// File: tests/can_frame_vectors.txt
// ide rtr id dlc data fault exp_dlc exp_kind, all hex
// fault 0 none, 1 CRC bit flip, 2 sixth equal bit, 3 recessive ACK, 4 dominant CRC delimiter
// kind 0 none, 1 stuff, 2 form, 3 crc, 4 ack
0 0 123 1 a5 0 1 0
0 0 7ff 2 1234 0 2 0
0 0 0f0 3 c0ffee 0 3 0
0 0 2a5 8 0123456789abcdef 0 8 0
0 1 155 2 0 0 2 0
0 0 000 0 0 0 0 0
1 0 1abcdef0 5 00ff00ff11 0 5 0
1 1 0badcafe 4 0 0 4 0
0 0 4c3 c fedcba9876543210 0 8 0
1 0 00012345 f 8000000000000001 0 8 0
0 0 321 2 beef 1 2 3
0 0 321 2 beef 0 2 0
// Id 00f puts the first stuff bit inside the identifier
0 0 00f 1 55 2 1 1
0 0 6a1 1 3c 3 1 4
0 0 1f0 2 abcd 4 2 2
0 0 0aa 4 deadbeef 0 4 0

// File: compile.f
+incdir+src
src/can_rx_pkg.sv
src/can_bit_if.sv
src/can_destuff.sv
src/can_crc15.sv
src/can_field_capture.sv
src/can_rx_control.sv
src/can_rx_top.sv
tests/tb_can_rx.sv
